/* rtl/rf_spi_pkg.sv */
package rf_spi_pkg;

    // frame format
    localparam int CMD_LEN = 24;                  // bits per command frame
    localparam int CLK_DIV = 2;                   // clk cycles per sclk half period
    localparam int SYNC_STAGES = 4;               // cpu chip select synchronizer depth

    // counter widths and compare points for the shifter
    localparam int DIV_CNT_W = $clog2(2 * CLK_DIV);
    localparam int BIT_CNT_W = $clog2(CMD_LEN + 1);
    localparam logic [DIV_CNT_W-1:0] DIV_HALF = DIV_CNT_W'(CLK_DIV - 1);     // last sclk high cycle
    localparam logic [DIV_CNT_W-1:0] DIV_LAST = DIV_CNT_W'(2 * CLK_DIV - 1); // last cycle of a bit
    localparam logic [BIT_CNT_W-1:0] BIT_LAST = BIT_CNT_W'(CMD_LEN);        // all bits sent

    typedef logic [CMD_LEN-1:0] cmd_t;

    // switch device commands
    localparam cmd_t CMD_TX_LOW = 24'h0C_01_05;   // rf port a, tx lo on
    localparam cmd_t CMD_TX_HIGH = 24'h0C_02_0A;  // rf port b, tx lo off

    typedef enum logic [1:0] {
        CTRL_DISABLED = 2'b00,                    // switching frozen on port a
        CTRL_IDLE = 2'b01,                        // waiting for a request and the bus
        CTRL_ACTIVE = 2'b11                       // frame in flight
    } ctrl_state_t;

endpackage

/* rtl/rf_spi_top.sv */
`timescale 1ns/100ps

module rf_spi_top (
    input  logic clk,
    input  logic rstn,
    input  logic tx_chain_on,
    input  logic spi_disable,
    input  logic cpu_sclk,
    input  logic cpu_mosi,
    input  logic cpu_csn,
    output logic spi_sclk,
    output logic spi_mosi,
    output logic spi_csn
);

    logic grant;
    logic eng_sclk;
    logic eng_mosi;
    logic eng_csn;

    spi_cmd_if cmd_bus ();   // controller to shifter requests

    rf_switch_ctrl rf_switch_ctrl_inst (
        .clk         (clk),
        .rstn        (rstn),
        .tx_chain_on (tx_chain_on),
        .spi_disable (spi_disable),
        .grant       (grant),
        .cmd         (cmd_bus.ctrl)
    );

    spi_shifter spi_shifter_inst (
        .clk      (clk),
        .rstn     (rstn),
        .cmd      (cmd_bus.shifter),
        .eng_sclk (eng_sclk),
        .eng_mosi (eng_mosi),
        .eng_csn  (eng_csn)
    );

    spi_bus_arbiter spi_bus_arbiter_inst (
        .clk      (clk),
        .rstn     (rstn),
        .cpu_sclk (cpu_sclk),
        .cpu_mosi (cpu_mosi),
        .cpu_csn  (cpu_csn),
        .eng_sclk (eng_sclk),
        .eng_mosi (eng_mosi),
        .eng_csn  (eng_csn),
        .eng_busy (cmd_bus.busy),
        .grant    (grant),
        .spi_sclk (spi_sclk),
        .spi_mosi (spi_mosi),
        .spi_csn  (spi_csn)
    );

endmodule

/* rtl/rf_switch_ctrl.sv */
`timescale 1ns/100ps

module rf_switch_ctrl
    import rf_spi_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        tx_chain_on,
    input  logic        spi_disable,
    input  logic        grant,
    spi_cmd_if.ctrl     cmd
);

    ctrl_state_t state;
    logic        tx_chain_on_old;
    logic        pending_low;      // tx high -> port a request
    logic        pending_high;     // port b request
    logic        sel_high;         // word in flight is CMD_TX_HIGH

    logic        tx_rise;
    logic        tx_fall;
    logic        set_low;
    logic        set_high;
    logic        clr_low;
    logic        clr_high;
    logic        enter_disabled;
    logic        issue_high;
    logic        issue;

    assign tx_rise = tx_chain_on & ~tx_chain_on_old;
    assign tx_fall = ~tx_chain_on & tx_chain_on_old;

    // edges are ignored while frozen on port a
    assign set_low = (state != CTRL_DISABLED) & (tx_rise | spi_disable);
    assign set_high = ((state != CTRL_DISABLED) & tx_fall) |
                      ((state == CTRL_DISABLED) & ~spi_disable);

    assign clr_low = (state == CTRL_ACTIVE) & cmd.done & ~sel_high;
    assign clr_high = (state == CTRL_ACTIVE) & cmd.done & sel_high;
    assign enter_disabled = clr_low & spi_disable;

    // port b must not be selected while the transmit chain is on
    assign issue_high = pending_high & ~tx_chain_on;
    assign issue = issue_high | pending_low;

    assign cmd.start = (state == CTRL_IDLE) & grant & issue;
    assign cmd.word = (state == CTRL_ACTIVE) ? (sel_high ? CMD_TX_HIGH : CMD_TX_LOW)
                                             : (issue_high ? CMD_TX_HIGH : CMD_TX_LOW);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= CTRL_IDLE;
            tx_chain_on_old <= 1'b0;
            pending_low <= 1'b0;
            pending_high <= 1'b0;
            sel_high <= 1'b0;
        end else begin
            tx_chain_on_old <= tx_chain_on;
            // a new request wins over the clear of a finished one
            pending_low <= enter_disabled ? 1'b0 : (set_low | (pending_low & ~clr_low));
            pending_high <= set_high | (pending_high & ~clr_high);
            case (state)
                CTRL_DISABLED: begin
                    if (!spi_disable) begin
                        state <= CTRL_IDLE;
                    end
                end
                CTRL_IDLE: begin
                    if (cmd.start) begin
                        sel_high <= issue_high;  // remembers which flag to clear
                        state <= CTRL_ACTIVE;
                    end
                end
                CTRL_ACTIVE: begin
                    if (cmd.done) begin
                        state <= enter_disabled ? CTRL_DISABLED : CTRL_IDLE;
                    end
                end
                default: state <= CTRL_IDLE;
            endcase
        end
    end

    // the shifter must be free before a new frame is requested
    a_no_start_while_busy : assert property (
        @(posedge clk) disable iff (!rstn) !(cmd.start && cmd.busy)
    );

endmodule

/* rtl/spi_bus_arbiter.sv */
`timescale 1ns/100ps

module spi_bus_arbiter
    import rf_spi_pkg::*;
(
    input  logic clk,
    input  logic rstn,
    input  logic cpu_sclk,
    input  logic cpu_mosi,
    input  logic cpu_csn,
    input  logic eng_sclk,
    input  logic eng_mosi,
    input  logic eng_csn,
    input  logic eng_busy,
    output logic grant,
    output logic spi_sclk,
    output logic spi_mosi,
    output logic spi_csn
);

    logic [SYNC_STAGES-1:0] csn_sync;      // cpu_csn is asynchronous to clk
    logic                   cpu_csn_sync;
    logic                   eng_sel;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            csn_sync <= '1;                // cpu treated as idle
        end else begin
            csn_sync <= {csn_sync[SYNC_STAGES-2:0], cpu_csn};
        end
    end

    assign cpu_csn_sync = csn_sync[SYNC_STAGES-1];

    // once a frame runs, busy keeps the grant until done
    assign grant = cpu_csn_sync | eng_busy;

    // engine owns the pins only while its chip select is active
    assign eng_sel = ~eng_csn;
    assign spi_sclk = eng_sel ? eng_sclk : cpu_sclk;
    assign spi_mosi = eng_sel ? eng_mosi : cpu_mosi;
    assign spi_csn = eng_sel ? eng_csn : cpu_csn;

    // a local frame may only begin while the cpu was seen idle
    a_start_on_idle_cpu : assert property (
        @(posedge clk) disable iff (!rstn) $fell(eng_csn) |-> $past(cpu_csn_sync)
    );

endmodule

/* rtl/spi_cmd_if.sv */
`timescale 1ns/100ps

interface spi_cmd_if
    import rf_spi_pkg::*;
();

    logic start;   // one-cycle request from the controller
    cmd_t word;    // command to shift, held while busy
    logic busy;    // shifter owns a frame
    logic done;    // frame finished, same cycle busy drops

    modport ctrl (
        output start,
        output word,
        input  busy,
        input  done
    );

    modport shifter (
        input  start,
        input  word,
        output busy,
        output done
    );

endinterface

/* rtl/spi_shifter.sv */
`timescale 1ns/100ps

module spi_shifter
    import rf_spi_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    spi_cmd_if.shifter  cmd,
    output logic        eng_sclk,
    output logic        eng_mosi,
    output logic        eng_csn
);

    cmd_t                 shreg;     // remaining bits, lsb goes out next
    logic [DIV_CNT_W-1:0] div_cnt;   // position inside the current bit
    logic [BIT_CNT_W-1:0] bit_cnt;   // bits started so far
    logic                 busy;
    logic                 done;

    assign cmd.busy = busy;
    assign cmd.done = done;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy <= 1'b0;
            done <= 1'b0;
            eng_csn <= 1'b1;
            eng_sclk <= 1'b0;
            eng_mosi <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (cmd.start) begin
                    busy <= 1'b1;
                    eng_csn <= 1'b0;
                    div_cnt <= DIV_LAST;     // one lead-in cycle before bit 0
                    bit_cnt <= '0;
                end
            end else if (div_cnt == DIV_LAST) begin
                if (bit_cnt == BIT_LAST) begin
                    busy <= 1'b0;            // frame complete
                    done <= 1'b1;
                    eng_csn <= 1'b1;
                    eng_sclk <= 1'b0;
                    eng_mosi <= 1'b0;
                end else begin
                    eng_sclk <= 1'b1;        // rising edge with new data
                    eng_mosi <= shreg[0];
                    bit_cnt <= bit_cnt + 1'b1;
                    div_cnt <= '0;
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
                if (div_cnt == DIV_HALF) begin
                    eng_sclk <= 1'b0;        // device samples here
                end
            end
        end
    end

    // payload loaded on start and shifted once per bit
    always_ff @(posedge clk) begin
        if (!busy && cmd.start) begin
            shreg <= cmd.word;
        end else if (busy && div_cnt == DIV_LAST && bit_cnt != BIT_LAST) begin
            shreg <= shreg >> 1;
        end
    end

    // sclk idles low outside a frame
    a_sclk_idle_low : assert property (
        @(posedge clk) disable iff (!rstn) eng_csn |-> !eng_sclk
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rf_spi_tb -f tb.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vrf_spi_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q -F '*** TEST PASSED ***'; then
    exit 0
fi
echo "pass message not found"
exit 1

/* tb.f */
rtl/rf_spi_pkg.sv
rtl/spi_cmd_if.sv
rtl/rf_switch_ctrl.sv
rtl/spi_shifter.sv
rtl/spi_bus_arbiter.sv
rtl/rf_spi_top.sv
tests/spi_frame_monitor.sv
tests/rf_spi_tb.sv

/* tests/rf_spi_tb.sv */
`timescale 1ns/100ps

module rf_spi_tb
    import rf_spi_pkg::*;
();

    logic   clk;
    logic   rstn;
    logic   tx_chain_on;
    logic   spi_disable;
    logic   cpu_sclk;
    logic   cpu_mosi;
    logic   cpu_csn;
    logic   spi_sclk;
    logic   spi_mosi;
    logic   spi_csn;
    cmd_t   mon_frame;
    int     mon_count;
    logic   mon_len_error;
    integer seed;
    int     seen;          // frames already compared
    cmd_t   exp_q[$];      // words the model expects next
    bit     m_disabled;
    bit     m_pend_low;
    bit     m_pend_high;

    always #50 clk = ~clk;

    rf_spi_top rf_spi_top_inst (
        .clk(clk), .rstn(rstn), .tx_chain_on(tx_chain_on), .spi_disable(spi_disable),
        .cpu_sclk(cpu_sclk), .cpu_mosi(cpu_mosi), .cpu_csn(cpu_csn),
        .spi_sclk(spi_sclk), .spi_mosi(spi_mosi), .spi_csn(spi_csn)
    );

    spi_frame_monitor monitor_inst (
        .rstn(rstn), .spi_sclk(spi_sclk), .spi_mosi(spi_mosi), .spi_csn(spi_csn),
        .cpu_csn(cpu_csn), .frame(mon_frame), .frame_count(mon_count),
        .len_error(mon_len_error)
    );

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            stop_on_failure($sformatf("Fail at %0t ns: %s is %0h, expected %0h",
                                      $time, name, got, expected));
        end
    endtask

    // one clk cycle that compares outputs and then drives the cpu pins
    task automatic step_cycle();
        cmd_t want;
        @(negedge clk);
        if (mon_len_error) stop_on_failure("frame on the spi pins had a wrong bit count");
        if (mon_count != seen) begin
            seen = mon_count;
            if (exp_q.size() == 0) stop_on_failure("local frame sent with no request pending");
            want = exp_q.pop_front();
            check_value("spi frame", 32'(mon_frame), 32'(want));
        end
        if (!cpu_csn || spi_csn) begin   // engine is off the pins
            check_value("spi_sclk", 32'(spi_sclk), 32'(cpu_sclk));
            check_value("spi_mosi", 32'(spi_mosi), 32'(cpu_mosi));
            check_value("spi_csn", 32'(spi_csn), 32'(cpu_csn));
        end
        cpu_sclk = cpu_csn ? 1'b0 : 1'($random(seed));
        cpu_mosi = 1'($random(seed));
    endtask

    // issue every request the bus and switch state allow, high first
    task automatic drain_model();
        while (cpu_csn && !m_disabled && ((m_pend_high && !tx_chain_on) || m_pend_low)) begin
            if (m_pend_high && !tx_chain_on) begin
                exp_q.push_back(CMD_TX_HIGH);
                m_pend_high = 1'b0;
            end else begin
                exp_q.push_back(CMD_TX_LOW);
                m_pend_low = 1'b0;
                m_disabled = spi_disable;   // port a frame under disable freezes the switch
            end
        end
    endtask

    task automatic wait_for_frames();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            step_cycle();
            cycles++;
            if (cycles > 600) stop_on_failure("timeout waiting for a command frame");
        end
        cycles = 0;
        while (cpu_csn && !spi_csn) begin   // local frame still on the pins
            step_cycle();
            cycles++;
            if (cycles > 200) stop_on_failure("timeout waiting for spi_csn to go high");
        end
        repeat (CMD_LEN * 2 * CLK_DIV + SYNC_STAGES + 16 + ($unsigned($random(seed)) % 64))
            step_cycle();
    endtask

    // kind 0 toggles tx_chain_on, 1 spi_disable, 2 cpu_csn
    task automatic apply_event(input int kind);
        case (kind)
            0: begin
                tx_chain_on = ~tx_chain_on;
                if (!m_disabled && tx_chain_on) m_pend_low = 1'b1;
                if (!m_disabled && !tx_chain_on) m_pend_high = 1'b1;
            end
            1: begin
                spi_disable = ~spi_disable;
                if (spi_disable && !m_disabled) m_pend_low = 1'b1;
                if (!spi_disable && m_disabled) begin
                    m_disabled = 1'b0;
                    m_pend_high = 1'b1;
                end
            end
            default: cpu_csn = ~cpu_csn;
        endcase
        drain_model();
        wait_for_frames();
    endtask

    initial begin
        seed = 32'h4400;
        clk = 1'b0;
        rstn = 1'b0;
        tx_chain_on = 1'b0;
        spi_disable = 1'b0;
        cpu_sclk = 1'b0;
        cpu_mosi = 1'b0;
        cpu_csn = 1'b1;
        seen = 0;
        m_disabled = 1'b0;
        m_pend_low = 1'b0;
        m_pend_high = 1'b0;
        repeat (10) @(negedge clk);
        rstn = 1'b1;
        step_cycle();
        check_value("spi_csn", 32'(spi_csn), 32'd1);
        repeat (200) step_cycle();   // quiet bus, pins follow the cpu
        apply_event(0);              // rising edge, then falling edge
        apply_event(0);
        apply_event(2);              // cpu holds the bus while edges merge
        apply_event(0);
        apply_event(0);
        apply_event(0);
        apply_event(2);
        apply_event(0);
        apply_event(1);              // disable, toggles are ignored, enable
        apply_event(0);
        apply_event(0);
        apply_event(1);
        repeat (120) apply_event($unsigned($random(seed)) % 3);
        if (!cpu_csn) apply_event(2);
        if (exp_q.size() != 0) begin
            stop_on_failure("expected frames never appeared on the spi pins");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

/* tests/spi_frame_monitor.sv */
`timescale 1ns/100ps

module spi_frame_monitor
    import rf_spi_pkg::*;
(
    input  logic rstn,
    input  logic spi_sclk,
    input  logic spi_mosi,
    input  logic spi_csn,
    input  logic cpu_csn,
    output cmd_t frame,
    output int   frame_count,
    output logic len_error
);

    cmd_t shift;
    int   bits;
    logic skip;

    initial begin
        frame = '0;
        frame_count = 0;
        len_error = 1'b0;
        forever begin
            @(negedge spi_csn);
            skip = ~cpu_csn | ~rstn;   // cpu transfer or reset glitch
            bits = 0;
            shift = '0;
            while (spi_csn == 1'b0) begin
                @(negedge spi_sclk or posedge spi_csn);
                if (spi_csn == 1'b0) begin
                    shift = {spi_mosi, shift[CMD_LEN-1:1]};   // lsb arrives first
                    bits = bits + 1;
                end
            end
            if (!skip) begin
                if (bits != CMD_LEN) begin
                    $display("spi frame ended after %0d bits instead of %0d", bits, CMD_LEN);
                    len_error = 1'b1;
                end
                frame = shift;
                frame_count = frame_count + 1;
            end
        end
    end

endmodule
